/* Makefile */
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -j 0
TOP        ?= tb_hybrid_bist
RTL_TOP    ?= hybrid_bist
FILELIST   ?= hybrid_bist.f
OBJ_DIR    ?= obj_dir
PASS_MSG   := TEST OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* bist_controller.sv */
// test sequencing FSM of the array self-test
// runs either the accumulator march or the stuck-at scan test and
// decodes all step strobes and status levels from the state
`default_nettype none

module bist_controller
    import bist_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic test_mode,
    input  logic bist_mode,           // 0 march, 1 scan
    input  logic march_write_last,
    input  logic march_read_last,
    input  logic march_done_last,
    input  logic scan_shift_last,
    input  logic scan_pattern_last,
    input  logic scan_first_pattern,
    input  logic mismatch,
    output logic march_clear,
    output logic march_write,
    output logic march_read,
    output logic scan_clear,
    output logic scan_shift,
    output logic scan_capture,
    output logic scan_en,
    output logic diagnosis_start_en,
    output logic detection_en,
    output logic acc_wr_en,
    output logic test_done,
    output logic mbist_fail
);

    bist_state_t state;
    bist_state_t state_nxt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (start && test_mode) begin
                    state_nxt = bist_mode ? SA_SHIFT : MBIST_WRITE;
                end
            end

            MBIST_WRITE: begin
                if (march_write_last) begin
                    state_nxt = MBIST_READ;
                end
            end

            MBIST_READ: begin
                if (mismatch) begin
                    state_nxt = FAIL;  // row r checked while row r+1 is addressed
                end else if (march_read_last) begin
                    state_nxt = MBIST_DRAIN;
                end
            end

            MBIST_DRAIN: begin
                // compare of the last row happens here
                if (mismatch) begin
                    state_nxt = FAIL;
                end else if (march_done_last) begin
                    state_nxt = TEST_COMPLETE;
                end else begin
                    state_nxt = MBIST_WRITE;
                end
            end

            SA_SHIFT: begin
                if (scan_shift_last) begin
                    state_nxt = SA_CAPTURE;
                end
            end

            SA_CAPTURE: begin
                state_nxt = scan_pattern_last ? SA_FINAL_SHIFT : SA_SHIFT;
            end

            SA_FINAL_SHIFT: begin
                if (scan_shift_last) begin
                    state_nxt = TEST_COMPLETE;
                end
            end

            TEST_COMPLETE, FAIL: begin
                if (!start) begin
                    state_nxt = IDLE;  // hold result until start is released
                end
            end

            default: state_nxt = IDLE;
        endcase
    end

    // sequencer steps
    assign march_clear  = (state == IDLE);
    assign march_write  = (state == MBIST_WRITE);
    assign march_read   = (state == MBIST_READ);
    assign scan_clear   = (state == IDLE);
    assign scan_shift   = (state == SA_SHIFT) || (state == SA_FINAL_SHIFT);
    assign scan_capture = (state == SA_CAPTURE);

    // array and diagnosis side
    assign scan_en            = scan_shift;
    assign diagnosis_start_en = ((state == SA_SHIFT) && !scan_first_pattern)
                                || (state == SA_FINAL_SHIFT);
    assign detection_en       = (state == SA_FINAL_SHIFT);  // last unload only
    assign acc_wr_en          = march_write;

    // status
    assign test_done  = (state == TEST_COMPLETE) || (state == FAIL);
    assign mbist_fail = (state == FAIL);

endmodule

`default_nettype wire

/* bist_pkg.sv */
// self-test constants for the systolic MAC array
// array sizes, scan and march pattern counts, the march nibble
// table and the encoding of the test controller states
`default_nettype none

package bist_pkg;

    localparam int LANES    = 8;  // array columns, also accumulator rows
    localparam int WEIGHT_W = 8;
    localparam int ACT_W    = 8;
    localparam int PSUM_W   = WEIGHT_W + ACT_W + $clog2(LANES);  // 19
    localparam int ADDR_W   = $clog2(LANES);

    // scan test
    localparam int SHIFT_LEN   = 8;   // cycles per scan load
    localparam int SA_PATTERNS = 12;

    // march test
    localparam int MBIST_PATTERNS = 8;
    localparam int PAT_IDX_W      = 4;

    // march pattern k is nibble k repeated over the psum width
    localparam logic [3:0] MBIST_NIBBLES [MBIST_PATTERNS] = '{
        4'h0, 4'hF, 4'h5, 4'hA, 4'h3, 4'hC, 4'h6, 4'h9
    };

    typedef enum logic [3:0] {
        IDLE,
        MBIST_WRITE,     // one write sweep over all rows
        MBIST_READ,      // one read sweep over all rows
        MBIST_DRAIN,     // last read data still in flight
        SA_SHIFT,
        SA_CAPTURE,
        SA_FINAL_SHIFT,  // unload of the last captured result
        TEST_COMPLETE,
        FAIL
    } bist_state_t;

endpackage

`default_nettype wire

/* hybrid_bist.f */
bist_pkg.sv
bist_controller.sv
mbist_sequencer.sv
scan_sequencer.sv
response_checker.sv
hybrid_bist.sv
tb_acc_memory.sv
tb_hybrid_bist.sv

/* hybrid_bist.sv */
// built-in self-test controller of the systolic MAC array
// march test on the accumulator rows and stuck-at scan test with
// lane-wise results for the external diagnosis unit
`default_nettype none

module hybrid_bist
    import bist_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  logic                      test_mode,
    input  logic                      bist_mode,
    input  logic [WEIGHT_W-1:0]       envm_weight,
    input  logic [ACT_W-1:0]          envm_activation,
    input  logic [PSUM_W-1:0]         envm_partial_sum_in,
    input  logic [PSUM_W-1:0]         envm_answer,
    input  logic [LANES*PSUM_W-1:0]   partial_sum_flat,  // accumulator read data
    output logic [PAT_IDX_W-1:0]      test_counter,
    output logic                      scan_en,
    output logic                      diagnosis_start_en,
    output logic                      detection_en,
    output logic [LANES-1:0]          compared_results,
    output logic [LANES*WEIGHT_W-1:0] weight_in_test_flat,
    output logic [LANES*ACT_W-1:0]    activation_in_test_flat,
    output logic [LANES*PSUM_W-1:0]   partial_sum_test_flat,
    output logic                      acc_wr_en,
    output logic [ADDR_W-1:0]         acc_wr_addr,
    output logic [LANES*PSUM_W-1:0]   acc_wr_data,
    output logic [ADDR_W-1:0]         acc_rd_addr,
    output logic                      mbist_fail,
    output logic                      test_done
);

    // controller strobes
    logic march_clear;
    logic march_write;
    logic march_read;
    logic scan_clear;
    logic scan_shift;
    logic scan_capture;

    // sequencer flags back to the controller
    logic march_write_last;
    logic march_read_last;
    logic march_done_last;
    logic scan_shift_last;
    logic scan_pattern_last;
    logic scan_first_pattern;

    logic [PSUM_W-1:0] pattern_word;
    logic              mismatch;

    bist_controller u_ctrl (
        .clk                (clk),
        .rst_n              (rst_n),
        .start              (start),
        .test_mode          (test_mode),
        .bist_mode          (bist_mode),
        .march_write_last   (march_write_last),
        .march_read_last    (march_read_last),
        .march_done_last    (march_done_last),
        .scan_shift_last    (scan_shift_last),
        .scan_pattern_last  (scan_pattern_last),
        .scan_first_pattern (scan_first_pattern),
        .mismatch           (mismatch),
        .march_clear        (march_clear),
        .march_write        (march_write),
        .march_read         (march_read),
        .scan_clear         (scan_clear),
        .scan_shift         (scan_shift),
        .scan_capture       (scan_capture),
        .scan_en            (scan_en),
        .diagnosis_start_en (diagnosis_start_en),
        .detection_en       (detection_en),
        .acc_wr_en          (acc_wr_en),
        .test_done          (test_done),
        .mbist_fail         (mbist_fail)
    );

    mbist_sequencer u_march (
        .clk          (clk),
        .rst_n        (rst_n),
        .clear        (march_clear),
        .write_step   (march_write),
        .read_step    (march_read),
        .acc_wr_addr  (acc_wr_addr),
        .acc_rd_addr  (acc_rd_addr),
        .acc_wr_data  (acc_wr_data),
        .pattern_word (pattern_word),
        .write_last   (march_write_last),
        .read_last    (march_read_last),
        .done_last    (march_done_last)
    );

    scan_sequencer u_scan (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .clear                   (scan_clear),
        .shift                   (scan_shift),
        .capture                 (scan_capture),
        .envm_weight             (envm_weight),
        .envm_activation         (envm_activation),
        .envm_partial_sum_in     (envm_partial_sum_in),
        .test_counter            (test_counter),
        .weight_in_test_flat     (weight_in_test_flat),
        .activation_in_test_flat (activation_in_test_flat),
        .partial_sum_test_flat   (partial_sum_test_flat),
        .shift_last              (scan_shift_last),
        .pattern_last            (scan_pattern_last),
        .first_pattern           (scan_first_pattern)
    );

    // answer is loaded at capture, checked on the following unload
    response_checker u_check (
        .clk              (clk),
        .rst_n            (rst_n),
        .pattern_word     (pattern_word),
        .envm_answer      (envm_answer),
        .load_answer      (scan_capture),
        .march_read       (march_read),
        .scan_check       (diagnosis_start_en),
        .partial_sum_flat (partial_sum_flat),
        .compared_results (compared_results),
        .mismatch         (mismatch)
    );

endmodule

`default_nettype wire

/* mbist_sequencer.sv */
// march address and pattern generation for the accumulator memory
// one row address shared by the write and read sweeps, a pattern
// index that steps after every read sweep, and the pattern word
`default_nettype none

module mbist_sequencer
    import bist_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    clear,
    input  logic                    write_step,
    input  logic                    read_step,
    output logic [ADDR_W-1:0]       acc_wr_addr,
    output logic [ADDR_W-1:0]       acc_rd_addr,
    output logic [LANES*PSUM_W-1:0] acc_wr_data,
    output logic [PSUM_W-1:0]       pattern_word,
    output logic                    write_last,
    output logic                    read_last,
    output logic                    done_last
);

    logic [ADDR_W-1:0]    row_addr;
    logic [PAT_IDX_W-1:0] march_idx;  // counts up to MBIST_PATTERNS
    logic                 row_last;
    logic [3:0]           nibble;

    assign row_last = (row_addr == ADDR_W'(LANES - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_addr  <= '0;
            march_idx <= '0;
        end else if (clear) begin
            row_addr  <= '0;
            march_idx <= '0;
        end else begin
            if (write_step || read_step) begin
                row_addr <= row_last ? '0 : row_addr + 1'b1;
            end
            if (read_step && row_last) begin
                march_idx <= march_idx + 1'b1;  // read sweep wrapped
            end
        end
    end

    // low index bits pick the nibble, index MBIST_PATTERNS is never written
    assign nibble = MBIST_NIBBLES[march_idx[$clog2(MBIST_PATTERNS)-1:0]];

    always_comb begin
        for (int b = 0; b < PSUM_W; b++) begin
            pattern_word[b] = nibble[b % 4];  // top copy truncated
        end
    end

    assign acc_wr_data = {LANES{pattern_word}};
    assign acc_wr_addr = row_addr;
    assign acc_rd_addr = row_addr;

    assign write_last = row_last;
    assign read_last  = row_last;
    // high once the read sweep of the last pattern has wrapped
    assign done_last  = (march_idx == PAT_IDX_W'(MBIST_PATTERNS));

endmodule

`default_nettype wire

/* response_checker.sv */
// lane-wise response compare for both self-tests
// keeps the expected value, either the march pattern or the eNVM
// answer, and flags every accumulator lane that differs from it
`default_nettype none

module response_checker
    import bist_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [PSUM_W-1:0]       pattern_word,
    input  logic [PSUM_W-1:0]       envm_answer,
    input  logic                    load_answer,
    input  logic                    march_read,
    input  logic                    scan_check,
    input  logic [LANES*PSUM_W-1:0] partial_sum_flat,
    output logic [LANES-1:0]        compared_results,
    output logic                    mismatch
);

    logic [PSUM_W-1:0] expected;
    logic              march_read_d;  // lines up with read data
    logic              check_en;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            march_read_d <= 1'b0;
        end else begin
            march_read_d <= march_read;
        end
    end

    // pattern word captured with the read address, used a cycle later
    always_ff @(posedge clk) begin
        if (load_answer) begin
            expected <= envm_answer;
        end else if (march_read) begin
            expected <= pattern_word;
        end
    end

    assign check_en = march_read_d || scan_check;

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            compared_results[i] = check_en
                && (partial_sum_flat[i*PSUM_W +: PSUM_W] != expected);
        end
    end

    assign mismatch = |compared_results;

endmodule

`default_nettype wire

/* scan_sequencer.sv */
// scan pattern sequencing for the stuck-at test
// counts shift cycles and captured patterns, addresses the eNVM and
// broadcasts the stimulus words to every array lane while shifting
`default_nettype none

module scan_sequencer
    import bist_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      clear,
    input  logic                      shift,
    input  logic                      capture,
    input  logic [WEIGHT_W-1:0]       envm_weight,
    input  logic [ACT_W-1:0]          envm_activation,
    input  logic [PSUM_W-1:0]         envm_partial_sum_in,
    output logic [PAT_IDX_W-1:0]      test_counter,
    output logic [LANES*WEIGHT_W-1:0] weight_in_test_flat,
    output logic [LANES*ACT_W-1:0]    activation_in_test_flat,
    output logic [LANES*PSUM_W-1:0]   partial_sum_test_flat,
    output logic                      shift_last,
    output logic                      pattern_last,
    output logic                      first_pattern
);

    logic [$clog2(SHIFT_LEN)-1:0] shift_cnt;
    logic [PAT_IDX_W-1:0]         pat_idx;

    assign shift_last = (shift_cnt == $bits(shift_cnt)'(SHIFT_LEN - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shift_cnt <= '0;
            pat_idx   <= '0;
        end else if (clear) begin
            shift_cnt <= '0;
            pat_idx   <= '0;
        end else begin
            if (shift) begin
                shift_cnt <= shift_last ? '0 : shift_cnt + 1'b1;
            end
            if (capture) begin
                pat_idx <= pat_idx + 1'b1;
            end
        end
    end

    assign test_counter  = pat_idx;  // eNVM pattern address
    assign pattern_last  = (pat_idx == PAT_IDX_W'(SA_PATTERNS - 1));
    assign first_pattern = (pat_idx == '0);

    // same stimulus on every lane
    assign weight_in_test_flat     = shift ? {LANES{envm_weight}} : '0;
    assign activation_in_test_flat = shift ? {LANES{envm_activation}} : '0;
    assign partial_sum_test_flat   = shift ? {LANES{envm_partial_sum_in}} : '0;

endmodule

`default_nettype wire

/* tb_acc_memory.sv */
// behavioral accumulator memory for the self-test testbench
// one row of all lanes per address, read data one cycle after the
// address, optional stuck-at-0 bit on one row
`default_nettype none

module tb_acc_memory
    import bist_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    wr_en,
    input  logic [ADDR_W-1:0]       wr_addr,
    input  logic [LANES*PSUM_W-1:0] wr_data,
    input  logic [ADDR_W-1:0]       rd_addr,
    input  logic                    fault_en,
    input  int                      fault_row,
    input  int                      fault_bit,  // lane * PSUM_W + bit
    output logic [LANES*PSUM_W-1:0] rd_data
);

    logic [LANES*PSUM_W-1:0] mem [LANES];
    logic [LANES*PSUM_W-1:0] stuck_mask;

    // faulty cell always reads back as zero
    assign stuck_mask = (fault_en && int'(rd_addr) == fault_row)
        ? (LANES*PSUM_W)'(1) << fault_bit : '0;

    always @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else begin
            rd_data <= mem[rd_addr] & ~stuck_mask;  // one cycle read
        end
    end

endmodule

`default_nettype wire

/* tb_hybrid_bist.sv */
// testbench of the array self-test controller
// runs the march with and without a stuck bit in the accumulator
// model, the scan test with and without a corrupted lane, and the
// idle cases; concurrent assertions check strobes and result timing
`default_nettype none

module tb_hybrid_bist
    import bist_pkg::*;
();

    logic                      clk = 1'b0;
    logic                      rst_n;
    logic                      start;
    logic                      test_mode;
    logic                      bist_mode;
    logic [WEIGHT_W-1:0]       envm_weight = '0;
    logic [ACT_W-1:0]          envm_activation = '0;
    logic [PSUM_W-1:0]         envm_partial_sum_in = '0;
    logic [PSUM_W-1:0]         envm_answer = '0;
    logic [LANES*PSUM_W-1:0]   partial_sum_flat;
    logic [PAT_IDX_W-1:0]      test_counter;
    logic                      scan_en;
    logic                      diagnosis_start_en;
    logic                      detection_en;
    logic [LANES-1:0]          compared_results;
    logic [LANES*WEIGHT_W-1:0] weight_in_test_flat;
    logic [LANES*ACT_W-1:0]    activation_in_test_flat;
    logic [LANES*PSUM_W-1:0]   partial_sum_test_flat;
    logic                      acc_wr_en;
    logic [ADDR_W-1:0]         acc_wr_addr;
    logic [LANES*PSUM_W-1:0]   acc_wr_data;
    logic [ADDR_W-1:0]         acc_rd_addr;
    logic                      mbist_fail;
    logic                      test_done;

    logic [LANES*PSUM_W-1:0] mem_rd_data;
    logic [LANES*PSUM_W-1:0] scan_psum = '0;  // shifted-out results during the scan test
    logic                    fault_en = 1'b0;
    int                      fault_row = 0;
    int                      fault_bit = 0;
    logic                    bad_on = 1'b0;
    int                      bad_lane = 0;
    logic                    busy = 1'b0;
    logic                    lb_on = 1'b0;
    logic                    exp_fail = 1'b0;
    int                      exp_len = 0;
    int                      cyc = 0;
    int                      start_cyc = 0;
    int                      t_run;       // cycles since the start cycle closed
    int                      wr_cnt;
    logic [PSUM_W-1:0]       exp_wr_word;
    logic [2:0]              exp_strobes;  // scan_en, diagnosis, detection
    logic [LANES-1:0]        exp_cmp;
    logic [6:0]              ctrl_outs;
    int                      march_pos;    // cycle within one march pattern
    logic                    march_on;
    int                      scan_idx;     // eNVM address of the current scan step
    logic                    stim_on;
    logic [LANES*(WEIGHT_W+ACT_W+PSUM_W)-1:0] stim_outs;
    logic [LANES*(WEIGHT_W+ACT_W+PSUM_W)-1:0] exp_stim;
    int                      err_idle = 0;
    int                      err_wr = 0;
    int                      err_addr = 0;
    int                      err_len = 0;
    int                      err_fail = 0;
    int                      err_strobe = 0;
    int                      err_cmp = 0;
    int                      err_stim = 0;
    int                      timeouts = 0;

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    hybrid_bist DUT (.*);

    tb_acc_memory u_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (acc_wr_en),
        .wr_addr   (acc_wr_addr),
        .wr_data   (acc_wr_data),
        .rd_addr   (acc_rd_addr),
        .fault_en  (fault_en),
        .fault_row (fault_row),
        .fault_bit (fault_bit),
        .rd_data   (mem_rd_data)
    );

    assign partial_sum_flat = bist_mode ? scan_psum : mem_rd_data;

    // LCG stream with a fixed number of steps per eNVM index and word
    function automatic logic [31:0] lcg_word(input int idx, input int salt);
        logic [31:0] x;
        x = 32'hf4eb_8d85;
        for (int i = 0; i <= idx * 4 + salt; i++) begin
            x = x * 32'd1664525 + 32'd1013904223;
        end
        return x;
    endfunction

    // nibble k repeated over the psum width
    function automatic logic [PSUM_W-1:0] march_word(input int k);
        logic [PSUM_W-1:0] w;
        for (int b = 0; b < PSUM_W; b++) begin
            w[b] = MBIST_NIBBLES[k % MBIST_PATTERNS][b % 4];
        end
        return w;
    endfunction

    function automatic int first_fail_pattern(input int bit_idx);
        logic [PSUM_W-1:0] w;
        for (int k = 0; k < MBIST_PATTERNS; k++) begin
            w = march_word(k);
            if (w[bit_idx]) begin
                return k;
            end
        end
        return -1;
    endfunction

    function automatic logic [2:0] scan_strobes(input int t);
        if (t >= SA_PATTERNS * (SHIFT_LEN + 1)) begin
            return 3'b111;  // final unload
        end
        if (t % (SHIFT_LEN + 1) == SHIFT_LEN) begin
            return 3'b000;  // capture
        end
        return {1'b1, t >= SHIFT_LEN + 1, 1'b0};
    endfunction

    // eNVM model addressed by test_counter
    always @(posedge clk) begin
        int idx;
        logic [PSUM_W-1:0] ans_prev;
        #2;
        idx = int'(test_counter);
        envm_answer         = PSUM_W'(lcg_word(idx, 0));
        envm_weight         = WEIGHT_W'(lcg_word(idx, 1));
        envm_activation     = ACT_W'(lcg_word(idx, 2));
        envm_partial_sum_in = PSUM_W'(lcg_word(idx, 3));
        ans_prev            = PSUM_W'(lcg_word(idx - 1, 0));
        for (int l = 0; l < LANES; l++) begin
            scan_psum[l*PSUM_W +: PSUM_W] = (bad_on && l == bad_lane)
                ? ans_prev ^ PSUM_W'(1) : ans_prev;
        end
    end

    // march writes seen so far and cleared at every test end
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_cnt <= 0;
        end else if (test_done) begin
            wr_cnt <= 0;
        end else if (acc_wr_en) begin
            wr_cnt <= wr_cnt + 1;
        end
    end

    assign t_run       = cyc - start_cyc;
    assign exp_wr_word = march_word(wr_cnt / LANES);
    assign exp_strobes = scan_strobes(t_run);
    assign exp_cmp     = (exp_strobes[1] && bad_on) ? LANES'(1) << bad_lane : '0;
    assign ctrl_outs   = {acc_wr_en, scan_en, diagnosis_start_en, detection_en,
                          test_done, mbist_fail, |compared_results};

    // write sweep, read sweep and drain of each march pattern
    assign march_pos = t_run % (2 * LANES + 1);
    assign march_on  = busy && !lb_on && t_run >= 0 && t_run < exp_len;

    // eNVM words of the current scan step on every lane while shifting
    assign scan_idx  = t_run / (SHIFT_LEN + 1);
    assign stim_on   = lb_on && t_run >= 0 && t_run < exp_len && exp_strobes[2];
    assign stim_outs = {weight_in_test_flat, activation_in_test_flat, partial_sum_test_flat};
    assign exp_stim  = stim_on ? {{LANES{WEIGHT_W'(lcg_word(scan_idx, 1))}},
                                  {LANES{ACT_W'(lcg_word(scan_idx, 2))}},
                                  {LANES{PSUM_W'(lcg_word(scan_idx, 3))}}} : '0;

    assert property (@(posedge clk) disable iff (!rst_n) !busy |-> ctrl_outs == '0)
    else begin
        err_idle++;
        $display("ERR %0t control outputs got %b exp %b", $time, $sampled(ctrl_outs), 7'b0);
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        acc_wr_en |-> acc_wr_data == {LANES{exp_wr_word}})
    else begin
        err_wr++;
        $display("ERR %0t acc_wr_data got %h exp %h", $time,
                 $sampled(acc_wr_data), {LANES{$sampled(exp_wr_word)}});
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        march_on |-> acc_wr_en == (march_pos < LANES))
    else begin
        err_wr++;
        $display("ERR %0t acc_wr_en got %b exp %b", $time,
                 $sampled(acc_wr_en), $sampled(march_pos) < LANES);
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        acc_wr_en |-> acc_wr_addr == ADDR_W'(wr_cnt % LANES))
    else begin
        err_addr++;
        $display("ERR %0t acc_wr_addr got %0d exp %0d", $time,
                 $sampled(acc_wr_addr), $sampled(wr_cnt) % LANES);
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        march_on && march_pos >= LANES && march_pos < 2 * LANES
        |-> acc_rd_addr == ADDR_W'(march_pos - LANES))
    else begin
        err_addr++;
        $display("ERR %0t acc_rd_addr got %0d exp %0d", $time,
                 $sampled(acc_rd_addr), $sampled(march_pos) - LANES);
    end

    assert property (@(posedge clk) disable iff (!rst_n) $rose(test_done) |-> t_run == exp_len)
    else begin
        err_len++;
        $display("ERR %0t test_done latency got %0d exp %0d", $time, $sampled(t_run), exp_len);
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(test_done) |-> mbist_fail == exp_fail)
    else begin
        err_fail++;
        $display("ERR %0t mbist_fail got %b exp %b", $time, $sampled(mbist_fail), exp_fail);
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        lb_on && t_run >= 0 && t_run < exp_len
        |-> {scan_en, diagnosis_start_en, detection_en, mbist_fail} == {exp_strobes, 1'b0})
    else begin
        err_strobe++;
        $display("ERR %0t scan strobes got %b exp %b", $time,
                 $sampled({scan_en, diagnosis_start_en, detection_en, mbist_fail}),
                 {$sampled(exp_strobes), 1'b0});
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        lb_on && t_run >= 0 && t_run < exp_len |-> compared_results == exp_cmp)
    else begin
        err_cmp++;
        $display("ERR %0t compared_results got %b exp %b", $time,
                 $sampled(compared_results), $sampled(exp_cmp));
    end

    assert property (@(posedge clk) disable iff (!rst_n) stim_outs == exp_stim)
    else begin
        err_stim++;
        $display("ERR %0t scan stimulus lanes got %h exp %h", $time,
                 $sampled(stim_outs), $sampled(exp_stim));
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        lb_on && t_run >= 0 && t_run < exp_len |-> test_counter == PAT_IDX_W'(scan_idx))
    else begin
        err_stim++;
        $display("ERR %0t test_counter got %0d exp %0d", $time,
                 $sampled(test_counter), $sampled(scan_idx));
    end

    task automatic wait_test_done(input logic level, input int limit);
        int n;
        n = 0;
        while (test_done !== level && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (test_done !== level) begin
            timeouts++;
            $display("timeout at %0t, test_done never went to %b", $time, level);
        end
    endtask

    task automatic run_test(input logic mode, input int len, input logic fail);
        @(posedge clk);
        #2;
        bist_mode = mode;
        test_mode = 1'b1;
        start     = 1'b1;
        exp_len   = len;
        exp_fail  = fail;
        lb_on     = mode;
        start_cyc = cyc + 1;  // edge that closes the start cycle
        busy      = 1'b1;
        wait_test_done(1'b1, len + 8);
        @(posedge clk);
        #2;
        start = 1'b0;
        wait_test_done(1'b0, 4);
        busy  = 1'b0;
        lb_on = 1'b0;
    endtask

    initial begin
        int k;
        rst_n     = 1'b0;
        start     = 1'b0;
        test_mode = 1'b0;
        bist_mode = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;
        repeat (3) @(posedge clk);
        #2;
        start = 1'b1;  // test_mode still low, must stay idle
        repeat (6) @(posedge clk);
        #2;
        start = 1'b0;

        run_test(1'b0, MBIST_PATTERNS * (2 * LANES + 1), 1'b0);

        // stuck-at-0 on the top bit of lane 2 in the last row
        fault_row = LANES - 1;
        fault_bit = 2 * PSUM_W + PSUM_W - 1;
        fault_en  = 1'b1;
        k = first_fail_pattern(PSUM_W - 1);
        run_test(1'b0, (2 * LANES + 1) * k + LANES + 2 + fault_row, 1'b1);
        fault_en = 1'b0;

        run_test(1'b1, SA_PATTERNS * (SHIFT_LEN + 1) + SHIFT_LEN, 1'b0);
        bad_lane = 5;
        bad_on   = 1'b1;
        run_test(1'b1, SA_PATTERNS * (SHIFT_LEN + 1) + SHIFT_LEN, 1'b0);
        bad_on = 1'b0;
        repeat (4) @(posedge clk);

        $write("errors: idle %0d write %0d addr %0d length %0d fail %0d",
               err_idle, err_wr, err_addr, err_len, err_fail);
        $display(" strobe %0d compare %0d stim %0d timeout %0d",
                 err_strobe, err_cmp, err_stim, timeouts);
        if (err_idle + err_wr + err_addr + err_len + err_fail + err_strobe + err_cmp
            + err_stim + timeouts == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
